//--- rtl/sprite_defines.svh
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// ------------------------------------------------------------
// screen geometry
// ------------------------------------------------------------
`define SCREEN_W          640      // pixels per line
`define SKY_LAST_LINE     10'd154  // last sky line
`define SKYLINE_LAST_LINE 10'd353  // ground starts below this
`define BG_TILE_W         10'd160  // one background quarter
`define FRAME_END_LINE    10'd520  // sword counter ticks here

// ------------------------------------------------------------
// sprite sizes and placements
// ------------------------------------------------------------
`define BIG_SPRITE        64       // player and movers
`define SMALL_SPRITE      32       // digits and life icons
`define NUM_MOVERS        4

`define DIGIT_X_HUN       10'd10   // score row at line 0
`define DIGIT_X_TEN       10'd50
`define DIGIT_X_ONE       10'd90

`define LIFE_X0           10'd480  // life row at line 0
`define LIFE_X1           10'd520
`define LIFE_X2           10'd560

// special colors, 4-4-4 rgb
`define COLOR_TRANSPARENT 12'hfff
`define COLOR_SKY         12'h0fe  // light blue
`define COLOR_GROUND      12'h000

`endif

//--- rtl/sprite_pkg.sv
`include "sprite_defines.svh"

package sprite_pkg;

  typedef logic [9:0]  pixel_x_t;  // column 0..639
  typedef logic [9:0]  line_y_t;
  typedef logic [11:0] color_t;    // r4 g4 b4
  typedef logic [3:0]  digit_t;    // bcd

  typedef struct packed {
    pixel_x_t x;  // top-left column
    line_y_t  y;  // top-left line
  } sprite_pos_t;

  // ------------------------------------------------------------
  // rom interface
  // ------------------------------------------------------------
  typedef struct packed {
    logic [13:0]                        player;  // frame, line, column
    logic [`NUM_MOVERS-1:0][11:0]       mover;
    logic [13:0]                        digit;   // digit value on top
    logic [9:0]                         life;
    logic [16:0]                        bg;      // quarter on top
  } rom_addr_t;

  typedef struct packed {
    color_t                   player;
    color_t [`NUM_MOVERS-1:0] mover;
    color_t                   life;
    color_t                   digit;
    color_t                   bg;
  } rom_data_t;

  typedef struct packed {
    logic                  player;
    logic [`NUM_MOVERS-1:0] mover;
    logic                  life;
    logic                  digit;
    logic                  skyline;
    logic                  sky;
  } hit_t;

  typedef enum logic [1:0] {STRAIGHT = 2'd0, RAISED = 2'd1, HIGH = 2'd2} sword_frame_e;

endpackage

//--- rtl/sprite_decode.sv
`include "sprite_defines.svh"

module sprite_decode (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  logic [10:0]                                hcount,
  input  sprite_pkg::line_y_t                        vcount,
  input  sprite_pkg::sprite_pos_t                    player_pos,
  input  sprite_pkg::sprite_pos_t [`NUM_MOVERS-1:0]  mover_pos,
  input  sprite_pkg::digit_t                         score_hun,
  input  sprite_pkg::digit_t                         score_ten,
  input  sprite_pkg::digit_t                         score_one,
  input  logic [2:0]                                 life_lost,
  output sprite_pkg::pixel_x_t                       col,
  output sprite_pkg::hit_t                           hit,
  output sprite_pkg::rom_addr_t                      rom_addr
);

  localparam sprite_pkg::pixel_x_t DIGIT_X [3] = '{`DIGIT_X_HUN, `DIGIT_X_TEN, `DIGIT_X_ONE};
  localparam sprite_pkg::pixel_x_t LIFE_X [3] = '{`LIFE_X0, `LIFE_X1, `LIFE_X2};

  sprite_pkg::pixel_x_t     player_dx;
  sprite_pkg::line_y_t      player_dy;
  sprite_pkg::pixel_x_t     mover_dx [`NUM_MOVERS];
  sprite_pkg::line_y_t      mover_dy [`NUM_MOVERS];
  sprite_pkg::pixel_x_t     digit_dx [3];
  sprite_pkg::pixel_x_t     life_dx [3];
  sprite_pkg::digit_t       score [3];
  logic [2:0]               digit_hit;
  logic [2:0]               life_hit;
  sprite_pkg::digit_t       digit_val;
  sprite_pkg::pixel_x_t     glyph_dx;
  sprite_pkg::pixel_x_t     icon_dx;
  logic [1:0]               quarter;
  sprite_pkg::pixel_x_t     tile_col;
  sprite_pkg::line_y_t      bg_line;
  logic [14:0]              bg_off;
  logic [3:0]               cnt;
  logic [3:0]               cnt_next;
  logic                     frame_end;
  sprite_pkg::sword_frame_e frame_q;
  sprite_pkg::sword_frame_e frame_next;

  assign col = hcount[10:1];  // two clocks per column

  // ------------------------------------------------------------
  // offsets from each placement
  // ------------------------------------------------------------
  assign player_dx = col - player_pos.x;
  assign player_dy = vcount - player_pos.y;
  assign score = '{score_hun, score_ten, score_one};

  always_comb begin
    for (int i = 0; i < `NUM_MOVERS; i++) begin
      mover_dx[i] = col - mover_pos[i].x;
      mover_dy[i] = vcount - mover_pos[i].y;  // wraps large when above
    end
    for (int j = 0; j < 3; j++) begin
      digit_dx[j] = col - DIGIT_X[j];
      life_dx[j]  = col - LIFE_X[j];
    end
  end

  // score place and life icon under the pixel
  always_comb begin
    digit_val = '0;
    glyph_dx  = '0;
    icon_dx   = '0;
    for (int j = 2; j >= 0; j--) begin
      digit_hit[j] = (vcount < `SMALL_SPRITE) && (digit_dx[j] < `SMALL_SPRITE);
      life_hit[j]  = (vcount < `SMALL_SPRITE) && (life_dx[j] < `SMALL_SPRITE) && !life_lost[j];
      if (digit_hit[j]) begin
        digit_val = score[j];
        glyph_dx  = digit_dx[j];
      end
      if (life_hit[j]) begin
        icon_dx = life_dx[j];
      end
    end
  end

  always_comb begin
    hit        = '0;
    hit.player = (player_dx < `BIG_SPRITE) && (player_dy < `BIG_SPRITE);
    for (int i = 0; i < `NUM_MOVERS; i++) begin
      hit.mover[i] = (mover_dx[i] < `BIG_SPRITE) && (mover_dy[i] < `BIG_SPRITE);
    end
    hit.life    = |life_hit;
    hit.digit   = |digit_hit;
    hit.sky     = vcount <= `SKY_LAST_LINE;
    hit.skyline = (vcount > `SKY_LAST_LINE) && (vcount <= `SKYLINE_LAST_LINE);
  end

  // ------------------------------------------------------------
  // background quarter and tile address
  // ------------------------------------------------------------
  always_comb begin
    if (col >= 3 * `BG_TILE_W) begin
      quarter = 2'd3;
    end else if (col >= 2 * `BG_TILE_W) begin
      quarter = 2'd2;
    end else if (col >= `BG_TILE_W) begin
      quarter = 2'd1;
    end else begin
      quarter = 2'd0;
    end
    tile_col = col - sprite_pkg::pixel_x_t'(quarter) * `BG_TILE_W;  // col mod 160
    bg_line  = vcount - (`SKY_LAST_LINE + 10'd1);
    bg_off   = 15'(bg_line) * 15'(`BG_TILE_W) + 15'(tile_col);
  end

  always_comb begin
    rom_addr = '0;  // unused fields stay zero
    if (hit.player) rom_addr.player = {frame_q, player_dy[5:0], player_dx[5:0]};
    for (int i = 0; i < `NUM_MOVERS; i++) begin
      if (hit.mover[i]) rom_addr.mover[i] = {mover_dy[i][5:0], mover_dx[i][5:0]};
    end
    if (hit.digit)   rom_addr.digit = {digit_val, vcount[4:0], glyph_dx[4:0]};
    if (hit.life)    rom_addr.life = {vcount[4:0], icon_dx[4:0]};
    if (hit.skyline) rom_addr.bg = {quarter, bg_off};
  end

  // ------------------------------------------------------------
  // sword animation, one step per frame
  // ------------------------------------------------------------
  assign frame_end = (vcount == `FRAME_END_LINE) && (hcount == 11'd0);
  assign cnt_next  = cnt + 4'd1;

  always_comb begin
    case (cnt_next[3:2])
      2'd0:    frame_next = sprite_pkg::STRAIGHT;
      2'd2:    frame_next = sprite_pkg::HIGH;
      default: frame_next = sprite_pkg::RAISED;  // on the way up and down
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      frame_q <= sprite_pkg::STRAIGHT;
    end else if (frame_end) begin
      cnt     <= cnt_next;
      frame_q <= frame_next;
    end
  end

  a_score_bcd: assert property (@(posedge clk) disable iff (!arst_n)
    (score_hun <= 4'd9) && (score_ten <= 4'd9) && (score_one <= 4'd9))
    else $error("score digit above 9");

endmodule

//--- rtl/pixel_priority.sv
`include "sprite_defines.svh"

module pixel_priority (
  input  sprite_pkg::hit_t      hit,
  input  sprite_pkg::rom_data_t rom_data,
  output sprite_pkg::color_t    pixel_color
);

  logic               player_vis;
  logic               mover_vis;
  sprite_pkg::color_t mover_color;
  logic               life_vis;
  logic               digit_vis;
  logic               bg_vis;

  // ------------------------------------------------------------
  // opaque tests per layer
  // ------------------------------------------------------------
  assign player_vis = hit.player && (rom_data.player != `COLOR_TRANSPARENT);
  assign life_vis   = hit.life && (rom_data.life != `COLOR_TRANSPARENT);
  assign digit_vis  = hit.digit && (rom_data.digit != `COLOR_TRANSPARENT);
  assign bg_vis     = hit.skyline && (rom_data.bg != `COLOR_TRANSPARENT);

  // lowest mover index wins, so scan from the top down
  always_comb begin
    mover_vis   = 1'b0;
    mover_color = '0;
    for (int i = `NUM_MOVERS - 1; i >= 0; i--) begin
      if (hit.mover[i] && (rom_data.mover[i] != `COLOR_TRANSPARENT)) begin
        mover_vis   = 1'b1;
        mover_color = rom_data.mover[i];
      end
    end
  end

  // ------------------------------------------------------------
  // fixed priority chain
  // ------------------------------------------------------------
  always_comb begin
    if (player_vis) begin
      pixel_color = rom_data.player;
    end else if (mover_vis) begin
      pixel_color = mover_color;
    end else if (life_vis) begin
      pixel_color = rom_data.life;
    end else if (digit_vis) begin
      pixel_color = rom_data.digit;
    end else if (bg_vis) begin
      pixel_color = rom_data.bg;
    end else if (hit.sky || hit.skyline) begin
      pixel_color = `COLOR_SKY;  // sky shows through skyline gaps
    end else begin
      pixel_color = `COLOR_GROUND;
    end
  end

endmodule

//--- rtl/line_buffer_out.sv
`include "sprite_defines.svh"

module line_buffer_out (
  input  logic                 clk,
  input  logic                 arst_n,
  input  sprite_pkg::pixel_x_t col,
  input  sprite_pkg::line_y_t  vcount,
  input  sprite_pkg::color_t   pixel_color,
  output logic [7:0]           vga_r,
  output logic [7:0]           vga_g,
  output logic [7:0]           vga_b
);

  sprite_pkg::color_t buf_even [`SCREEN_W];  // filled on even lines
  sprite_pkg::color_t buf_odd  [`SCREEN_W];  // filled on odd lines
  sprite_pkg::color_t rd_color;
  logic               wr_odd;

  assign wr_odd = vcount[0];

  // ------------------------------------------------------------
  // ping-pong write, current line
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_odd) begin
      buf_odd[col] <= pixel_color;
    end else begin
      buf_even[col] <= pixel_color;
    end
  end

  // previous line comes from the other buffer
  assign rd_color = wr_odd ? buf_even[col] : buf_odd[col];

  // ------------------------------------------------------------
  // rgb output, nibbles doubled to 8 bits
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vga_r <= '0;
      vga_g <= '0;
      vga_b <= '0;
    end else begin
      vga_r <= {rd_color[11:8], rd_color[11:8]};
      vga_g <= {rd_color[7:4], rd_color[7:4]};
      vga_b <= {rd_color[3:0], rd_color[3:0]};
    end
  end

  a_col_range: assert property (@(posedge clk) disable iff (!arst_n)
    col < `SCREEN_W)
    else $error("column outside the visible line");

endmodule

//--- rtl/rgb_controller.sv
`include "sprite_defines.svh"

module rgb_controller (
  input  logic                                       clk,
  input  logic                                       arst_n,
  input  logic [10:0]                                hcount,
  input  sprite_pkg::line_y_t                        vcount,
  input  sprite_pkg::sprite_pos_t                    player_pos,
  input  sprite_pkg::sprite_pos_t [`NUM_MOVERS-1:0]  mover_pos,
  input  sprite_pkg::digit_t                         score_hun,
  input  sprite_pkg::digit_t                         score_ten,
  input  sprite_pkg::digit_t                         score_one,
  input  logic [2:0]                                 life_lost,
  input  sprite_pkg::rom_data_t                      rom_data,
  output sprite_pkg::rom_addr_t                      rom_addr,
  output logic [7:0]                                 vga_r,
  output logic [7:0]                                 vga_g,
  output logic [7:0]                                 vga_b
);

  sprite_pkg::pixel_x_t col;          // column of the current pixel
  sprite_pkg::hit_t     hit;
  sprite_pkg::color_t   pixel_color;  // composited, into the buffer

  // ------------------------------------------------------------
  // decode, execute, result
  // ------------------------------------------------------------
  sprite_decode u_sprite_decode (
    .clk        (clk),
    .arst_n     (arst_n),
    .hcount     (hcount),
    .vcount     (vcount),
    .player_pos (player_pos),
    .mover_pos  (mover_pos),
    .score_hun  (score_hun),
    .score_ten  (score_ten),
    .score_one  (score_one),
    .life_lost  (life_lost),
    .col        (col),
    .hit        (hit),
    .rom_addr   (rom_addr)
  );

  pixel_priority u_pixel_priority (
    .hit         (hit),
    .rom_data    (rom_data),   // answers in the same cycle
    .pixel_color (pixel_color)
  );

  line_buffer_out u_line_buffer_out (
    .clk         (clk),
    .arst_n      (arst_n),
    .col         (col),
    .vcount      (vcount),
    .pixel_color (pixel_color),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b)
  );

endmodule

//--- verification/tb_sprite_model.svh
`ifndef TB_SPRITE_MODEL_SVH
`define TB_SPRITE_MODEL_SVH

// ------------------------------------------------------------
// rom models, each color a fold of its address
// ------------------------------------------------------------
function automatic sprite_pkg::color_t fold_color(input logic [16:0] addr, input logic [11:0] key);
  sprite_pkg::color_t c;
  c = addr[11:0] ^ {addr[16:12], 7'd0} ^ key;
  if (c == `COLOR_TRANSPARENT) c = key;  // keys are never all ones
  return c;
endfunction

function automatic sprite_pkg::color_t player_rom(input logic [13:0] addr);
  if (addr[5:0] >= 6'd60) return `COLOR_TRANSPARENT;  // right strip is clear
  return fold_color({3'd0, addr}, 12'h5a3);
endfunction

function automatic sprite_pkg::color_t mover_rom(input int idx, input logic [11:0] addr);
  logic [11:0] key;
  case (idx)
    0:       key = 12'h2b4;
    1:       key = 12'h3e1;
    2:       key = 12'h46d;
    default: key = 12'h719;
  endcase
  if (addr[5:0] == 6'd0) return `COLOR_TRANSPARENT;  // left column is clear
  return fold_color({5'd0, addr}, key);
endfunction

function automatic sprite_pkg::color_t digit_rom(input logic [13:0] addr);
  if (addr[4:0] >= 5'd28) return `COLOR_TRANSPARENT;
  return fold_color({3'd0, addr}, 12'h6c2);
endfunction

function automatic sprite_pkg::color_t life_rom(input logic [9:0] addr);
  if (addr[4:0] < 5'd2) return `COLOR_TRANSPARENT;
  return fold_color({7'd0, addr}, 12'h93b);
endfunction

function automatic sprite_pkg::color_t bg_rom(input logic [16:0] addr);
  if (addr[7:0] == 8'd0) return `COLOR_TRANSPARENT;  // gaps in the skyline
  return fold_color(addr, 12'ha05);
endfunction

// ------------------------------------------------------------
// reference pixel, layers in priority order
// ------------------------------------------------------------
function automatic sprite_pkg::color_t expected_color(input scenario_t s, input logic [1:0] frame);
  int v;
  int c;
  int dx;
  int dy;
  int life_x [3];
  int digit_x [3];
  sprite_pkg::digit_t digit [3];
  sprite_pkg::color_t rc;
  v = int'(s.line);
  c = int'(s.col);
  life_x = '{`LIFE_X0, `LIFE_X1, `LIFE_X2};
  digit_x = '{`DIGIT_X_HUN, `DIGIT_X_TEN, `DIGIT_X_ONE};
  digit = '{s.hun, s.ten, s.one};
  dx = c - int'(s.player.x);
  dy = v - int'(s.player.y);
  if (dx >= 0 && dx < `BIG_SPRITE && dy >= 0 && dy < `BIG_SPRITE) begin
    rc = player_rom({frame, 6'(dy), 6'(dx)});
    if (rc != `COLOR_TRANSPARENT) return rc;
  end
  for (int i = 0; i < `NUM_MOVERS; i++) begin
    dx = c - int'(s.movers[i].x);
    dy = v - int'(s.movers[i].y);
    if (dx >= 0 && dx < `BIG_SPRITE && dy >= 0 && dy < `BIG_SPRITE) begin
      rc = mover_rom(i, {6'(dy), 6'(dx)});
      if (rc != `COLOR_TRANSPARENT) return rc;
    end
  end
  if (v < `SMALL_SPRITE) begin
    for (int i = 0; i < 3; i++) begin
      dx = c - life_x[i];
      if (dx >= 0 && dx < `SMALL_SPRITE && !s.life_lost[i]) begin
        rc = life_rom({5'(v), 5'(dx)});
        if (rc != `COLOR_TRANSPARENT) return rc;
      end
    end
    for (int i = 0; i < 3; i++) begin
      dx = c - digit_x[i];
      if (dx >= 0 && dx < `SMALL_SPRITE) begin
        rc = digit_rom({digit[i], 5'(v), 5'(dx)});
        if (rc != `COLOR_TRANSPARENT) return rc;
      end
    end
  end
  if (v > 154 && v <= 353) begin
    rc = bg_rom({2'(c / 160), 15'((v - 155) * 160 + c % 160)});
    if (rc != `COLOR_TRANSPARENT) return rc;
    return `COLOR_SKY;  // sky behind the skyline gaps
  end
  if (v <= 154) return `COLOR_SKY;
  return `COLOR_GROUND;
endfunction

`endif

//--- verification/tb_rgb_controller.sv
`include "sprite_defines.svh"

module tb_rgb_controller;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    sprite_pkg::sprite_pos_t                   player;
    sprite_pkg::sprite_pos_t [`NUM_MOVERS-1:0] movers;
    sprite_pkg::digit_t                        hun;
    sprite_pkg::digit_t                        ten;
    sprite_pkg::digit_t                        one;
    logic [2:0]                                life_lost;
    sprite_pkg::line_y_t                       line;   // probe line
    sprite_pkg::pixel_x_t                      col;    // probe column
    logic [3:0]                                ticks;  // frame ends before the probe
  } scenario_t;

  `include "tb_sprite_model.svh"

  logic                                      clk = 1'b0;
  logic                                      arst_n;
  logic [10:0]                               hcount;
  sprite_pkg::line_y_t                       vcount;
  sprite_pkg::sprite_pos_t                   player_pos;
  sprite_pkg::sprite_pos_t [`NUM_MOVERS-1:0] mover_pos;
  sprite_pkg::digit_t                        score_hun;
  sprite_pkg::digit_t                        score_ten;
  sprite_pkg::digit_t                        score_one;
  logic [2:0]                                life_lost;
  sprite_pkg::rom_data_t                     rom_data;
  sprite_pkg::rom_addr_t                     rom_addr;
  logic [7:0]                                vga_r;
  logic [7:0]                                vga_g;
  logic [7:0]                                vga_b;

  scenario_t table_q [$];
  string     name_q [$];
  integer    seed = 32'h70f;
  int        cycle_cnt = 0;
  int        errors = 0;
  int        checks = 0;
  int        bad_tests = 0;
  int        frame_ticks = 0;  // frame-end pulses seen by the dut
  bit        timed_out = 1'b0;

  always #50 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // roms answer in the same cycle
  always_comb begin
    rom_data.player = player_rom(rom_addr.player);
    for (int i = 0; i < `NUM_MOVERS; i++) rom_data.mover[i] = mover_rom(i, rom_addr.mover[i]);
    rom_data.life  = life_rom(rom_addr.life);
    rom_data.digit = digit_rom(rom_addr.digit);
    rom_data.bg    = bg_rom(rom_addr.bg);
  end

  rgb_controller u_rgb_controller (
    .clk, .arst_n, .hcount, .vcount, .player_pos, .mover_pos, .score_hun, .score_ten,
    .score_one, .life_lost, .rom_data, .rom_addr, .vga_r, .vga_g, .vga_b
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic wait_clocks(input int n);  // returns 5 ns after the n-th edge
    int target;
    int guard;
    target = cycle_cnt + n;
    guard  = 0;
    if (!timed_out) begin
      while (cycle_cnt < target && guard < n * 100 + 200) begin
        #1;
        guard++;
      end
      if (cycle_cnt < target) begin
        timed_out = 1'b1;
        $display("timeout: clock edge missing after %0d ns", guard);
      end else begin
        #4;
      end
    end
  endtask

  task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp);
    end
  endtask

  function automatic logic [1:0] frame_after(input int ticks);
    case ((ticks % 16) / 4)
      0:       return sprite_pkg::STRAIGHT;
      2:       return sprite_pkg::HIGH;
      default: return sprite_pkg::RAISED;  // up and back down
    endcase
  endfunction

  function automatic scenario_t parked();
    scenario_t s;
    s = '0;
    s.player.y = 10'd900;  // far below the visible lines
    for (int i = 0; i < `NUM_MOVERS; i++) s.movers[i].y = 10'd900;
    s.life_lost = 3'b111;
    return s;
  endfunction

  task automatic add_row(input scenario_t s, input sprite_pkg::line_y_t line,
                         input sprite_pkg::pixel_x_t col, input string name);
    s.line = line;
    s.col  = col;
    table_q.push_back(s);
    name_q.push_back(name);
  endtask

  task automatic pulse_frame_end();
    vcount = `FRAME_END_LINE;
    hcount = 11'd0;
    wait_clocks(1);
    hcount = 11'd2;  // off column 0 so it counts once
    wait_clocks(1);
    frame_ticks++;
  endtask

  // ------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------
  task automatic build_table();
    scenario_t s;
    s = parked();
    add_row(s, 10'd100, 10'd300, "sky above the skyline");
    add_row(s, 10'd155, 10'd0, "clear skyline texel shows sky");
    add_row(s, 10'd200, 10'd50, "skyline quarter 0");
    add_row(s, 10'd200, 10'd170, "skyline quarter 1");
    add_row(s, 10'd200, 10'd400, "skyline quarter 2");
    add_row(s, 10'd353, 10'd630, "skyline quarter 3 last line");
    add_row(s, 10'd400, 10'd320, "ground below the skyline");
    s = parked();
    s.player.x    = 10'd200;
    s.player.y    = 10'd300;
    s.movers[0].x = 10'd220;
    s.movers[0].y = 10'd300;
    add_row(s, 10'd310, 10'd230, "player covers mover 0");
    add_row(s, 10'd310, 10'd262, "clear player texel shows mover 0");
    s = parked();
    s.movers[1].x = 10'd100;
    s.movers[1].y = 10'd250;
    s.movers[2].x = 10'd110;
    s.movers[2].y = 10'd250;
    add_row(s, 10'd260, 10'd120, "mover 1 over mover 2");
    s.movers[0].x = 10'd120;
    s.movers[0].y = 10'd250;
    add_row(s, 10'd260, 10'd120, "clear mover 0 texel shows mover 1");
    s = parked();
    s.movers[3].x = 10'd500;
    s.movers[3].y = 10'd420;
    add_row(s, 10'd430, 10'd530, "mover 3 alone on ground");
    for (int k = 0; k < 3; k++) begin
      s = parked();
      s.hun = 4'($unsigned($random(seed)) % 10);
      s.ten = 4'($unsigned($random(seed)) % 10);
      s.one = 4'($unsigned($random(seed)) % 10);
      add_row(s, 10'(5 + k * 7), 10'(20 + k * 40),  // one row per score place
              $sformatf("score place %0d digits %0d%0d%0d", k, s.hun, s.ten, s.one));
    end
    s = parked();
    s.life_lost = 3'b000;
    add_row(s, 10'd20, 10'd490, "life icon 0 shown");
    s.life_lost = 3'b001;
    add_row(s, 10'd20, 10'd490, "life icon 0 lost");
    s.life_lost = 3'b011;
    add_row(s, 10'd20, 10'd570, "life icon 2 shown");
    s.life_lost = 3'b100;
    add_row(s, 10'd20, 10'd570, "life icon 2 lost");
    s = parked();
    s.player.x = 10'd300;
    s.player.y = 10'd450;
    s.ticks    = 4'd4;
    add_row(s, 10'd460, 10'd330, "sword raised after 4 frames");
    add_row(s, 10'd460, 10'd330, "sword high after 8 frames");
  endtask

  task automatic run_row(input int idx);
    scenario_t          s;
    sprite_pkg::color_t exp_c;
    int                 errs_before;
    s = table_q[idx];
    errs_before = errors;
    repeat (s.ticks) pulse_frame_end();
    player_pos = s.player;
    mover_pos  = s.movers;
    score_hun  = s.hun;
    score_ten  = s.ten;
    score_one  = s.one;
    life_lost  = s.life_lost;
    vcount = s.line;
    hcount = {s.col, 1'b0};
    wait_clocks(1);  // written into this line's buffer
    vcount = s.line + 10'd1;
    wait_clocks(1);  // read back while the next line runs
    exp_c = expected_color(s, frame_after(frame_ticks));
    check_value("vga_r", vga_r, {exp_c[11:8], exp_c[11:8]});
    check_value("vga_g", vga_g, {exp_c[7:4], exp_c[7:4]});
    check_value("vga_b", vga_b, {exp_c[3:0], exp_c[3:0]});
    if (errors == errs_before) begin
      $display("test %0d %s: ok", idx + 1, name_q[idx]);
    end else begin
      bad_tests++;
      $display("test %0d %s: mismatch", idx + 1, name_q[idx]);
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    hcount     = '0;
    vcount     = '0;
    player_pos = '0;
    mover_pos  = '0;
    score_hun  = '0;
    score_ten  = '0;
    score_one  = '0;
    life_lost  = 3'b111;
    build_table();
    wait_clocks(3);
    check_value("vga_r", vga_r, 0);
    check_value("vga_g", vga_g, 0);
    check_value("vga_b", vga_b, 0);
    $display("test 0 outputs zero in reset: %s", (errors == 0) ? "ok" : "mismatch");
    if (errors != 0) bad_tests++;
    arst_n = 1'b1;
    for (int i = 0; i < table_q.size(); i++) begin
      if (timed_out) break;
      run_row(i);
    end
    $display("%0d tests, %0d with mismatches, %0d checks, %0d wrong values",
             table_q.size() + 1, bad_tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+rtl
+incdir+verification
rtl/sprite_pkg.sv
rtl/sprite_decode.sv
rtl/pixel_priority.sv
rtl/line_buffer_out.sv
rtl/rgb_controller.sv
verification/tb_rgb_controller.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rgb_controller testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module tb_rgb_controller \
  -f list.f --Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build did not complete"
  exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
